//--- hw/pianoPkg.sv
package pianoPkg;

  typedef logic [7:0]        scanCode_t;
  typedef logic [3:0]        noteCode_t;  // 0 = C4 .. 12 = C5
  typedef logic [7:0]        period_t;    // samples per tone cycle
  typedef logic [7:0]        phase_t;
  typedef logic signed [15:0] sample_t;
  typedef logic [5:0]        noteIndex_t;
  typedef logic [1:0]        songSel_t;

  localparam scanCode_t BREAK_CODE = 8'hF0; // key release prefix
  localparam int NUM_KEYS = 13;
  localparam int SAMPLE_DIV = 562;          // roughly 48 kHz from 27 MHz
  localparam int DIV_W = $clog2(SAMPLE_DIV);
  localparam int MAX_NOTES = 51;

  // make codes in note order Z S X D C V G B H N J M comma
  localparam scanCode_t KEY_CODES [NUM_KEYS] = '{
    8'h1A, 8'h1B, 8'h22, 8'h23, 8'h21, 8'h2A, 8'h34,
    8'h32, 8'h33, 8'h31, 8'h3B, 8'h3A, 8'h41
  };

  localparam period_t NOTE_PERIODS [NUM_KEYS] = '{
    8'd179, 8'd169, 8'd160, 8'd151, 8'd142, 8'd134, 8'd127,
    8'd120, 8'd113, 8'd107, 8'd101, 8'd95, 8'd90
  };

  localparam period_t DEFAULT_PERIOD = 8'd179;
  localparam sample_t SINE_PEAK = 16'sd32767;

  // first quadrant of a 256 step sine
  localparam sample_t SINE_QUARTER [64] = '{
        0,   804,  1608,  2410,  3212,  4011,  4808,  5602,
     6393,  7179,  7962,  8739,  9512, 10278, 11039, 11793,
    12539, 13279, 14010, 14732, 15446, 16151, 16846, 17530,
    18204, 18868, 19519, 20159, 20787, 21403, 22005, 22594,
    23170, 23731, 24279, 24811, 25329, 25832, 26319, 26790,
    27245, 27683, 28105, 28510, 28898, 29268, 29621, 29956,
    30273, 30571, 30852, 31113, 31356, 31580, 31785, 31971,
    32137, 32285, 32412, 32521, 32609, 32678, 32728, 32757
  };

  function automatic sample_t sineSample(input phase_t phase);
    logic [5:0] idx;
    logic [5:0] mirror;
    sample_t    mag;
    idx = phase[5:0];
    mirror = 6'd0 - idx;              // 64 - idx within the quadrant
    if (phase[6])
      mag = (idx == 6'd0) ? SINE_PEAK : SINE_QUARTER[mirror];
    else
      mag = SINE_QUARTER[idx];
    return phase[7] ? -mag : mag;     // second half is negative
  endfunction

  localparam noteCode_t SONG_NOTES [4][MAX_NOTES] = '{
    '{0, 0, 7, 7, 9, 9, 7, 5, 5, 4, 4, 2, 2, 0,  // twinkle twinkle
      7, 7, 5, 5, 4, 4, 2, 7, 7, 5, 5, 4, 4, 2,
      0, 0, 7, 7, 9, 9, 7, 5, 5, 4, 4, 2, 2, 0,
      0, 0, 0, 0, 0, 0, 0, 0, 0},
    '{0, 0, 2, 0, 5, 4, 0, 0, 2, 0, 7, 5, 0,     // happy birthday
      0, 12, 9, 5, 4, 2, 10, 10, 9, 5, 7, 5,
      0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
      0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
    '{4, 2, 0, 2, 4, 4, 4, 2, 2, 2, 4, 7, 7,     // mary had a little lamb
      4, 2, 0, 2, 4, 4, 4, 4, 2, 2, 4, 2, 0,
      0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
      0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
    '{4, 4, 4, 4, 4, 4, 4, 7, 0, 2, 4, 5, 5,     // jingle bells
      5, 5, 5, 4, 4, 4, 4, 4, 2, 2, 4, 2, 7,
      4, 4, 4, 4, 4, 4, 4, 7, 0, 2, 4, 5, 5,
      5, 5, 5, 4, 4, 4, 4, 7, 7, 5, 2, 0}
  };

  localparam noteIndex_t SONG_LAST [4] = '{6'd41, 6'd24, 6'd25, 6'd50};

endpackage

//--- hw/ps2Receiver.sv
`timescale 1ns/100ps

module ps2Receiver (
  input  logic                CLOCK_27,
  input  logic                RST,
  input  logic                ps2Clk,
  input  logic                ps2Dat,
  output pianoPkg::scanCode_t scanCode,
  output logic                scanStrobe
);
  import pianoPkg::*;

  logic [1:0] clkSync;   // two-flop synchronizer
  logic [1:0] datSync;
  logic       clkPrev;
  logic       clkFall;
  logic       inFrame;
  logic [3:0] bitCount;  // 0..7 data, 8 parity, 9 stop
  scanCode_t  shiftReg;

  always_ff @(posedge CLOCK_27 or negedge RST)
  begin
    if (!RST)
    begin
      clkSync <= 2'b11;  // lines idle high
      datSync <= 2'b11;
      clkPrev <= 1'b1;
    end
    else
    begin
      clkSync <= {clkSync[0], ps2Clk};
      datSync <= {datSync[0], ps2Dat};
      clkPrev <= clkSync[1];
    end
  end

  assign clkFall = clkPrev & ~clkSync[1];

  always_ff @(posedge CLOCK_27 or negedge RST)
  begin
    if (!RST)
    begin
      inFrame    <= 1'b0;
      bitCount   <= 4'd0;
      scanStrobe <= 1'b0;
    end
    else
    begin
      scanStrobe <= 1'b0;
      if (clkFall)
      begin
        if (!inFrame)
        begin
          inFrame  <= ~datSync[1];  // start bit is low
          bitCount <= 4'd0;
        end
        else if (bitCount == 4'd9)
        begin
          inFrame    <= 1'b0;       // stop bit, frame done
          bitCount   <= 4'd0;
          scanStrobe <= 1'b1;
        end
        else
          bitCount <= bitCount + 4'd1; // parity just counted
      end
    end
  end

  // data arrives lsb first
  always_ff @(posedge CLOCK_27)
  begin
    if (clkFall && inFrame && bitCount < 4'd8)
      shiftReg <= {datSync[1], shiftReg[7:1]};
  end

  assign scanCode = shiftReg;

endmodule

//--- hw/keyDecoder.sv
`timescale 1ns/100ps

module keyDecoder (
  input  logic                CLOCK_27,
  input  logic                RST,
  input  pianoPkg::scanCode_t scanCode,
  input  logic                scanStrobe,
  output logic                keyDown,
  output pianoPkg::period_t   period,
  output pianoPkg::noteCode_t noteCode,
  output logic                noteStrobe
);
  import pianoPkg::*;

  logic      releasePending; // set after F0, eats the next code
  logic      keyHit;
  noteCode_t keyIdx;

  // table search over the thirteen make codes
  always_comb
  begin
    keyHit = 1'b0;
    keyIdx = 4'd0;
    for (int i = 0; i < NUM_KEYS; i++)
    begin
      if (scanCode == KEY_CODES[i])
      begin
        keyHit = 1'b1;
        keyIdx = noteCode_t'(i);
      end
    end
  end

  always_ff @(posedge CLOCK_27 or negedge RST)
  begin
    if (!RST)
    begin
      releasePending <= 1'b0;
      keyDown        <= 1'b0;
      period         <= DEFAULT_PERIOD;
      noteCode       <= 4'd0;
      noteStrobe     <= 1'b0;
    end
    else
    begin
      noteStrobe <= 1'b0;
      if (scanStrobe)
      begin
        if (releasePending)
          releasePending <= 1'b0;    // code of the released key
        else if (scanCode == BREAK_CODE)
        begin
          keyDown        <= 1'b0;
          releasePending <= 1'b1;
        end
        else if (keyHit)
        begin
          keyDown    <= 1'b1;
          period     <= NOTE_PERIODS[keyIdx];
          noteCode   <= keyIdx;
          noteStrobe <= 1'b1;
        end
        else
        begin
          keyDown <= 1'b0;           // not a piano key
          period  <= DEFAULT_PERIOD;
        end
      end
    end
  end

endmodule

//--- hw/toneGenerator.sv
`timescale 1ns/100ps

module toneGenerator (
  input  logic              CLOCK_27,
  input  logic              RST,
  input  logic              keyDown,
  input  pianoPkg::period_t period,
  output logic              sampleStrobe,
  output pianoPkg::sample_t toneSample
);
  import pianoPkg::*;

  logic [DIV_W-1:0] divCount;
  phase_t           phase;

  // audio sample tick
  always_ff @(posedge CLOCK_27 or negedge RST)
  begin
    if (!RST)
    begin
      divCount     <= '0;
      sampleStrobe <= 1'b0;
    end
    else if (divCount == DIV_W'(SAMPLE_DIV - 1))
    begin
      divCount     <= '0;
      sampleStrobe <= 1'b1;
    end
    else
    begin
      divCount     <= divCount + 1'b1;
      sampleStrobe <= 1'b0;
    end
  end

  // phase wraps at the note period and stays at zero when idle
  always_ff @(posedge CLOCK_27 or negedge RST)
  begin
    if (!RST)
    begin
      phase      <= 8'd0;
      toneSample <= 16'sd0;
    end
    else if (sampleStrobe)
    begin
      if (keyDown && phase < period - 8'd1)
        phase <= phase + 8'd1;
      else
        phase <= 8'd0;
      if (keyDown)
        toneSample <= sineSample(phase); // phase before the step
      else
        toneSample <= 16'sd0;
    end
  end

endmodule

//--- hw/songTutor.sv
`timescale 1ns/100ps

module songTutor (
  input  logic                 CLOCK_27,
  input  logic                 RST,
  input  pianoPkg::songSel_t   songSel,
  input  pianoPkg::noteCode_t  noteCode,
  input  logic                 noteStrobe,
  output pianoPkg::noteIndex_t noteIndex,
  output pianoPkg::noteCode_t  expectedNote
);
  import pianoPkg::*;

  noteIndex_t lastIdx;
  logic       noteMatch;

  assign lastIdx = SONG_LAST[songSel];

  // out of table range only right after a song change
  always_comb
  begin
    if (int'(noteIndex) < MAX_NOTES)
      expectedNote = SONG_NOTES[songSel][noteIndex];
    else
      expectedNote = SONG_NOTES[songSel][0];
  end

  assign noteMatch = noteStrobe && (noteCode == expectedNote);

  always_ff @(posedge CLOCK_27 or negedge RST)
  begin
    if (!RST)
      noteIndex <= 6'd0;
    else if (noteIndex > lastIdx)
      noteIndex <= 6'd0;       // shorter song selected
    else if (noteMatch)
    begin
      if (noteIndex == lastIdx)
        noteIndex <= 6'd0;     // song finished, start over
      else
        noteIndex <= noteIndex + 6'd1;
    end
  end

endmodule

//--- hw/pianoTutorTop.sv
`timescale 1ns/100ps

module pianoTutorTop (
  input  logic                 CLOCK_27,
  input  logic                 RST,
  input  logic                 PS2_CLK,
  input  logic                 PS2_DAT,
  input  pianoPkg::songSel_t   songSel,
  output logic                 keyDown,
  output pianoPkg::period_t    period,
  output pianoPkg::sample_t    toneSample,
  output logic                 sampleStrobe,
  output pianoPkg::noteIndex_t noteIndex,
  output pianoPkg::noteCode_t  expectedNote
);
  import pianoPkg::*;

  scanCode_t scanCode;
  logic      scanStrobe;
  noteCode_t noteCode;
  logic      noteStrobe;

  ps2Receiver i_ps2Receiver (
    .CLOCK_27   (CLOCK_27),
    .RST        (RST),
    .ps2Clk     (PS2_CLK),
    .ps2Dat     (PS2_DAT),
    .scanCode   (scanCode),
    .scanStrobe (scanStrobe)
  );

  keyDecoder i_keyDecoder (
    .CLOCK_27   (CLOCK_27),
    .RST        (RST),
    .scanCode   (scanCode),
    .scanStrobe (scanStrobe),
    .keyDown    (keyDown),
    .period     (period),
    .noteCode   (noteCode),
    .noteStrobe (noteStrobe)
  );

  toneGenerator i_toneGenerator (
    .CLOCK_27     (CLOCK_27),
    .RST          (RST),
    .keyDown      (keyDown),
    .period       (period),
    .sampleStrobe (sampleStrobe),
    .toneSample   (toneSample)
  );

  songTutor i_songTutor (
    .CLOCK_27     (CLOCK_27),
    .RST          (RST),
    .songSel      (songSel),
    .noteCode     (noteCode),
    .noteStrobe   (noteStrobe),
    .noteIndex    (noteIndex),
    .expectedNote (expectedNote)
  );

endmodule

//--- tb/pianoTutor_props.sv
`timescale 1ns/100ps

module pianoTutor_props (
  input logic                 CLOCK_27,
  input logic                 RST,
  input logic                 keyDown,
  input logic                 sampleStrobe,
  input pianoPkg::sample_t    toneSample,
  input pianoPkg::noteIndex_t noteIndex
);
  import pianoPkg::*;

  // longest song ends at index 50
  indexInRange: assert property (@(posedge CLOCK_27) disable iff (!RST)
    noteIndex <= 6'd50)
    else $error("noteIndex %0d beyond the longest song", noteIndex);

  silentWhenIdle: assert property (@(posedge CLOCK_27) disable iff (!RST)
    (sampleStrobe && !keyDown) |=> (toneSample == 16'sd0))
    else $error("toneSample not zero after a tick with no key held");

  strobeSingle: assert property (@(posedge CLOCK_27) disable iff (!RST)
    sampleStrobe |=> !sampleStrobe)
    else $error("sampleStrobe high for two cycles");

  // key and tutor state cleared during reset
  resetState: assert property (@(posedge CLOCK_27)
    !RST |-> (!keyDown && noteIndex == 6'd0))
    else $error("keyDown or noteIndex not cleared during reset");

endmodule

bind pianoTutorTop pianoTutor_props i_pianoTutorProps (
  .CLOCK_27     (CLOCK_27),
  .RST          (RST),
  .keyDown      (keyDown),
  .sampleStrobe (sampleStrobe),
  .toneSample   (toneSample),
  .noteIndex    (noteIndex)
);

//--- tb/pianoTutorTb.sv
`timescale 1ns/100ps

module pianoTutorTb;
  import pianoPkg::*;

  localparam int CLK_PERIOD = 40;        // ns
  localparam int DRIVE_DLY = 2;          // ns after the rising edge
  localparam int BIT_CYCLES = 40;        // PS/2 bit time
  localparam int FRAME_CYCLES = 11 * BIT_CYCLES;
  localparam int SETTLE_CYCLES = 10;
  localparam int EXTRA_FRAMES = 40;      // tone, release and song frames
  localparam int TONE_EXTRA = 4;         // ticks past one full period
  localparam int TONE_NOTE = 12;         // comma key, shortest period
  localparam int TUTOR_SONG = 2;

  logic       CLOCK_27;
  logic       RST;
  logic       PS2_CLK;
  logic       PS2_DAT;
  songSel_t   songSel;
  logic       keyDown;
  period_t    period;
  sample_t    toneSample;
  logic       sampleStrobe;
  noteIndex_t noteIndex;
  noteCode_t  expectedNote;

  string patName [$];
  int    patSel [$];
  int    patCode [$];
  int    patKey [$];
  int    patPeriod [$];
  int    patIndex [$];
  int    patNote [$];
  int    patternCount = 0;
  bit    patternsLoaded = 1'b0;
  int    errorCount = 0;
  int    testsRun = 0;
  int    testsFailed = 0;
  int    testErrors = 0;
  int    expIndex = 0;       // tutor position the model expects

  pianoTutorTop i_pianoTutorTop (
    .CLOCK_27     (CLOCK_27),
    .RST          (RST),
    .PS2_CLK      (PS2_CLK),
    .PS2_DAT      (PS2_DAT),
    .songSel      (songSel),
    .keyDown      (keyDown),
    .period       (period),
    .toneSample   (toneSample),
    .sampleStrobe (sampleStrobe),
    .noteIndex    (noteIndex),
    .expectedNote (expectedNote)
  );

  always #(CLK_PERIOD / 2) CLOCK_27 = ~CLOCK_27;

  task automatic waitCycles(input int n);
    repeat (n) @(posedge CLOCK_27);
    #DRIVE_DLY;
  endtask

  // start, 8 data bits lsb first, odd parity, stop
  task automatic sendFrame(input scanCode_t code);
    logic [10:0] bits;
    bits = {1'b1, ~^code, code, 1'b0};
    for (int i = 0; i < 11; i++)
    begin
      PS2_DAT = bits[i];
      waitCycles(BIT_CYCLES / 2);
      PS2_CLK = 1'b0;               // device shifts on the falling edge
      waitCycles(BIT_CYCLES / 2);
      PS2_CLK = 1'b1;
    end
  endtask

  task automatic settle();
    repeat (SETTLE_CYCLES) @(negedge CLOCK_27);
  endtask

  task automatic checkValue(input string test, input string field,
                            input int expected, input int actual);
    assert (expected == actual)
    else
    begin
      $display("[FAIL] %s %s expected %0d actual %0d", test, field, expected, actual);
      errorCount++;
      testErrors++;
    end
  endtask

  task automatic finishTest(input string test);
    testsRun++;
    if (testErrors == 0)
      $display("test %s: ok", test);
    else
    begin
      testsFailed++;
      $display("test %s: %0d error(s)", test, testErrors);
    end
    testErrors = 0;
  endtask

  // tutor advances only on the expected note, wrapping after the last one
  function automatic int nextIndex(input int sel, input int idx, input int note);
    if (note != SONG_NOTES[sel][idx])
      return idx;
    if (idx == SONG_LAST[sel])
      return 0;
    return idx + 1;
  endfunction

  // returns the sample registered on the next tick
  task automatic nextSample(output sample_t value);
    while (!sampleStrobe)
      @(negedge CLOCK_27);
    @(negedge CLOCK_27);
    value = toneSample;
  endtask

  // one tick every SAMPLE_DIV clocks
  task automatic measureTickSpacing();
    int gap;
    while (!sampleStrobe)
      @(negedge CLOCK_27);
    gap = 1;
    @(negedge CLOCK_27);
    while (!sampleStrobe)
    begin
      @(negedge CLOCK_27);
      gap++;
    end
    checkValue("sampleTick", "sampleStrobe spacing", SAMPLE_DIV, gap);
    finishTest("sampleTick");
  endtask

  task automatic loadPatterns();
    int    fd;
    int    n;
    string line;
    string name;
    int    sel, code, kd, per, idx, note;
    fd = $fopen("tb/keyPatterns.txt", "r");
    if (fd == 0)
    begin
      $display("error: pattern file tb/keyPatterns.txt could not be opened");
      errorCount++;
      return;
    end
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() == 0 || line[0] == "#")
        continue;                   // column description
      n = $sscanf(line, "%s %d %h %d %d %d %d", name, sel, code, kd, per, idx, note);
      if (n == 7)
      begin
        patName.push_back(name);
        patSel.push_back(sel);
        patCode.push_back(code);
        patKey.push_back(kd);
        patPeriod.push_back(per);
        patIndex.push_back(idx);
        patNote.push_back(note);
      end
      else if (n > 0)
      begin
        $display("error: malformed pattern line: %s", line);
        errorCount++;
      end
    end
    $fclose(fd);
    patternCount = patName.size();
  endtask

  task automatic runPattern(input int i);
    @(posedge CLOCK_27);
    #DRIVE_DLY;
    songSel = songSel_t'(patSel[i]);
    sendFrame(scanCode_t'(patCode[i]));
    settle();
    checkValue(patName[i], "keyDown", patKey[i], keyDown);
    checkValue(patName[i], "period", patPeriod[i], period);
    checkValue(patName[i], "noteIndex", patIndex[i], noteIndex);
    checkValue(patName[i], "expectedNote", patNote[i], expectedNote);
    finishTest(patName[i]);
  endtask

  task automatic checkTone(input int note);
    int      per;
    int      waitCount;
    sample_t value;
    per = NOTE_PERIODS[note];
    for (int k = 0; k < 3; k++)
    begin
      nextSample(value);
      checkValue("toneIdle", "toneSample", 0, value);  // no key held
    end
    finishTest("toneIdle");
    @(posedge CLOCK_27);
    #DRIVE_DLY;
    fork
      sendFrame(KEY_CODES[note]);
      begin
        waitCount = 0;
        while (!keyDown && waitCount < 2 * FRAME_CYCLES)
        begin
          @(negedge CLOCK_27);
          waitCount++;
        end
        if (!keyDown)
        begin
          $display("error: keyDown did not rise after the key press for toneWave");
          errorCount++;
          testErrors++;
        end
        else
        begin
          for (int k = 0; k < per + TONE_EXTRA; k++)
          begin
            nextSample(value);
            checkValue("toneWave", "toneSample", sineSample(phase_t'(k % per)), value);
          end
        end
      end
    join
    expIndex = nextIndex(TUTOR_SONG, expIndex, note);
    finishTest("toneWave");
  endtask

  task automatic releaseKey(input int note);
    sample_t value;
    @(posedge CLOCK_27);
    #DRIVE_DLY;
    sendFrame(BREAK_CODE);
    sendFrame(KEY_CODES[note]);     // eaten by the release prefix
    settle();
    checkValue("toneRelease", "keyDown", 0, keyDown);
    for (int k = 0; k < 2; k++)
    begin
      nextSample(value);
      checkValue("toneRelease", "toneSample", 0, value);
    end
    finishTest("toneRelease");
  endtask

  task automatic playNote(input int note);
    @(posedge CLOCK_27);
    #DRIVE_DLY;
    sendFrame(KEY_CODES[note]);
    settle();
    expIndex = nextIndex(TUTOR_SONG, expIndex, note);
    checkValue("songReplay", "noteIndex", expIndex, noteIndex);
    checkValue("songReplay", "expectedNote", SONG_NOTES[TUTOR_SONG][expIndex], expectedNote);
  endtask

  task automatic replaySong();
    int steps;
    int wrong;
    songSel = songSel_t'(TUTOR_SONG);
    wrong = (int'(SONG_NOTES[TUTOR_SONG][expIndex]) + 1) % NUM_KEYS;
    playNote(wrong);                // must not advance
    steps = 0;
    do
    begin
      playNote(SONG_NOTES[TUTOR_SONG][expIndex]);
      steps++;
    end
    while (expIndex != 0 && steps <= MAX_NOTES);
    finishTest("songReplay");
    checkValue("songWrap", "noteIndex", 0, noteIndex);
    checkValue("songWrap", "expectedNote", SONG_NOTES[TUTOR_SONG][0], expectedNote);
    finishTest("songWrap");
  endtask

  initial
  begin
    CLOCK_27 = 1'b0;
    RST = 1'b1;
    PS2_CLK = 1'b1;                 // PS/2 lines idle high
    PS2_DAT = 1'b1;
    songSel = songSel_t'(TUTOR_SONG);
    loadPatterns();
    patternsLoaded = 1'b1;
    #1 RST = 1'b0;
    repeat (3) @(posedge CLOCK_27);
    #DRIVE_DLY RST = 1'b1;
    @(negedge CLOCK_27);
    checkValue("resetState", "keyDown", 0, keyDown);
    checkValue("resetState", "period", DEFAULT_PERIOD, period);
    checkValue("resetState", "noteIndex", 0, noteIndex);
    checkValue("resetState", "toneSample", 0, toneSample);
    finishTest("resetState");
    measureTickSpacing();
    for (int i = 0; i < patternCount; i++)
      runPattern(i);
    if (patternCount > 0)
      expIndex = patIndex[patternCount - 1];
    checkTone(TONE_NOTE);
    releaseKey(TONE_NOTE);
    replaySong();
    $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
    if (errorCount == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // limit from frame count and the longest tone period
  initial
  begin : watchdog
    longint limitNs;
    wait (patternsLoaded);
    limitNs = longint'(patternCount + EXTRA_FRAMES) * 12 * (FRAME_CYCLES + SETTLE_CYCLES)
              * CLK_PERIOD
              + longint'(2) * NOTE_PERIODS[0] * SAMPLE_DIV * CLK_PERIOD
              + 100000;
    #(limitNs);
    $display("timeout: the run did not finish within %0d ns", limitNs);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- tb/keyPatterns.txt
# name songSel scanCode(hex) keyDown period noteIndex expectedNote
# expected values hold after the frame and 10 settling cycles
keyC4 2 1A 1 179 0 4
keyCs4 2 1B 1 169 0 4
keyD4 2 22 1 160 0 4
keyDs4 2 23 1 151 0 4
keyE4 2 21 1 142 1 2
keyF4 2 2A 1 134 1 2
keyFs4 2 34 1 127 1 2
keyG4 2 32 1 120 1 2
keyGs4 2 33 1 113 1 2
keyA4 2 31 1 107 1 2
keyAs4 2 3B 1 101 1 2
keyB4 2 3A 1 95 1 2
keyC5 2 41 1 90 1 2
breakPrefix 2 F0 0 90 1 2
breakKey 2 41 0 90 1 2
pressD 2 22 1 160 2 0
unknownCode 2 1C 0 179 2 0
pressAfterUnknown 2 1A 1 179 3 2
breakAgain 2 F0 0 179 3 2
releaseZ 2 1A 0 179 3 2
wrongNoteE 2 21 1 142 3 2
breakE 2 F0 0 142 3 2
releaseE 2 21 0 142 3 2
doubleBreak 2 F0 0 142 3 2
doubleBreakEaten 2 F0 0 142 3 2
pressAfterDouble 2 22 1 160 4 4
breakD 2 F0 0 160 4 4
releaseD 2 22 0 160 4 4

//--- sim.f
hw/pianoPkg.sv
hw/ps2Receiver.sv
hw/keyDecoder.sv
hw/toneGenerator.sv
hw/songTutor.sv
hw/pianoTutorTop.sv
tb/pianoTutor_props.sv
tb/pianoTutorTb.sv
